// ==== frontend_pkg.sv ====
package frontend_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int VADDR_W  = 32;
  localparam int XLEN_W   = 32;
  localparam int CMT_ID_W = 5;   // Wrap bit on top, 4-bit index below
  localparam int INT_W    = 6;

  typedef logic [VADDR_W-1:0]  vaddr_t;    // Fetch and target addresses
  typedef logic [XLEN_W-1:0]   xlen_t;     // CSR values
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // Pending interrupts, highest priority on bit 5
  //   5 M external   4 S external
  //   3 M timer      2 S timer
  //   1 M software   0 S software
  typedef logic [INT_W-1:0] int_vec_t;

  // ==================================================
  // Interrupt cause codes, indexed by pending bit
  // ==================================================
  localparam logic [INT_W-1:0][3:0] INT_CAUSE = {
    4'd11,  // M external
    4'd9,   // S external
    4'd7,   // M timer
    4'd5,   // S timer
    4'd3,   // M software
    4'd1    // S software
  };

  // ==================================================
  // Commit causes
  // ==================================================
  // Exception values equal their medeleg bit index.
  // Flush and return commits sit above the exception codes in use.
  typedef enum logic [3:0] {
    SILENT_FLUSH   = 4'd12,  // Resume at epc+4
    REFETCH_FLUSH  = 4'd13,  // Resume at epc
    MRET           = 4'd14,
    SRET           = 4'd15,
    ECALL_U        = 4'd8,
    ECALL_S        = 4'd9,
    ECALL_M        = 4'd11,
    INST_ACC_FAULT = 4'd1,
    ILLEGAL_INST   = 4'd2
  } commit_cause_t;

  // Fetch sequencer states
  typedef enum logic [1:0] {
    INIT         = 2'd0,
    FETCH_REQ    = 2'd1,
    WAIT_IC_FILL = 2'd2
  } fetch_state_t;

endpackage

// ==== trap_target_unit.sv ====
`timescale 1ns/1ps

module trap_target_unit (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // Interrupt request
  input  logic                        i_int_valid,
  input  frontend_pkg::int_vec_t      i_int_pending,

  // Commit
  input  logic                        i_commit_valid,
  input  logic                        i_commit_flush,
  input  frontend_pkg::commit_cause_t i_commit_cause,
  input  frontend_pkg::vaddr_t        i_commit_epc,

  // CSR values
  input  frontend_pkg::xlen_t         i_mtvec,
  input  frontend_pkg::xlen_t         i_stvec,
  input  frontend_pkg::xlen_t         i_mepc,
  input  frontend_pkg::xlen_t         i_sepc,
  input  frontend_pkg::xlen_t         i_medeleg,

  output logic                        o_trap_valid,
  output frontend_pkg::vaddr_t        o_trap_vaddr
);

  import frontend_pkg::*;

  logic       w_cmt_flush;
  logic [3:0] w_int_cause;
  vaddr_t     w_mtvec_base;
  vaddr_t     w_int_vaddr;
  vaddr_t     w_exc_vaddr;
  vaddr_t     w_cmt_vaddr;

  assign w_cmt_flush  = i_commit_valid & i_commit_flush;
  assign w_mtvec_base = vaddr_t'({i_mtvec[XLEN_W-1:2], 2'b00});  // Mode bits dropped

  // ==================================================
  // Interrupt target
  // ==================================================
  // Scan upward so the highest pending bit wins
  always_comb begin
    w_int_cause = INT_CAUSE[0];
    for (int i = 0; i < INT_W; i++) begin
      if (i_int_pending[i]) begin
        w_int_cause = INT_CAUSE[i];
      end
    end
  end

  assign w_int_vaddr = w_mtvec_base + vaddr_t'({w_int_cause, 2'b00});  // Vectored entry

  // ==================================================
  // Commit flush target
  // ==================================================
  // Delegated exceptions go to the supervisor handler
  assign w_exc_vaddr = i_medeleg[i_commit_cause] ? vaddr_t'(i_stvec) : vaddr_t'(i_mtvec);

  always_comb begin
    case (i_commit_cause)
      SILENT_FLUSH  : w_cmt_vaddr = i_commit_epc + vaddr_t'(4);
      REFETCH_FLUSH : w_cmt_vaddr = i_commit_epc;
      MRET          : w_cmt_vaddr = vaddr_t'(i_mepc);
      SRET          : w_cmt_vaddr = vaddr_t'(i_sepc);
      default       : w_cmt_vaddr = w_exc_vaddr;  // ECALL_x, faults
    endcase
  end

  // Interrupt outranks any commit in the same cycle
  assign o_trap_valid = i_int_valid | w_cmt_flush;
  assign o_trap_vaddr = i_int_valid ? w_int_vaddr : w_cmt_vaddr;

  // Interrupt controller only strobes with a cause present
  a_int_has_pending : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_int_valid |-> (|i_int_pending)
  );

endmodule

// ==== branch_redirect_filter.sv ====
`timescale 1ns/1ps

module branch_redirect_filter (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // Mispredict report
  input  logic                  i_br_mispredict,
  input  frontend_pkg::cmt_id_t i_br_cmt_id,
  input  frontend_pkg::vaddr_t  i_br_target,

  // Commit
  input  logic                  i_commit_valid,
  input  logic                  i_commit_flush,
  input  frontend_pkg::cmt_id_t i_commit_cmt_id,

  output logic                  o_br_valid,
  output frontend_pkg::vaddr_t  o_br_vaddr
);

  import frontend_pkg::*;

  localparam int IDX_W = CMT_ID_W - 1;  // Position of the wrap bit

  logic    r_rec_valid;
  cmt_id_t r_rec_cmt_id;   // Last accepted mispredict
  logic    w_cmt_flush;
  logic    w_same_wrap;
  logic    w_rec_older;
  logic    w_accept;
  logic    w_rec_clear;

  assign w_cmt_flush = i_commit_valid & i_commit_flush;

  // ==================================================
  // Age check against the record
  // ==================================================
  assign w_same_wrap = r_rec_cmt_id[IDX_W] == i_br_cmt_id[IDX_W];

  // Index order flips once the wrap bits differ
  assign w_rec_older = w_same_wrap ?
                       (r_rec_cmt_id[IDX_W-1:0] < i_br_cmt_id[IDX_W-1:0]) :
                       (r_rec_cmt_id[IDX_W-1:0] > i_br_cmt_id[IDX_W-1:0]);

  // A flushing commit kills every in-flight branch
  assign w_accept = i_br_mispredict & ~w_cmt_flush & ~(r_rec_valid & w_rec_older);

  assign w_rec_clear = w_cmt_flush |
                       (r_rec_valid & i_commit_valid & (i_commit_cmt_id == r_rec_cmt_id));

  // ==================================================
  // Record
  // ==================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rec_valid <= 1'b0;
    end else if (w_accept) begin
      r_rec_valid <= 1'b1;  // New record beats a clear
    end else if (w_rec_clear) begin
      r_rec_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_rec_cmt_id <= i_br_cmt_id;
    end
  end

  assign o_br_valid = w_accept;
  assign o_br_vaddr = i_br_target;

  // Flushing commit leaves no record behind
  a_flush_clears_record : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_commit_valid && i_commit_flush) |=> !r_rec_valid
  );

endmodule

// ==== fetch_pc_sequencer.sv ====
`timescale 1ns/1ps

module fetch_pc_sequencer #(
  parameter int unsigned          FETCH_BYTES = 16,
  parameter frontend_pkg::vaddr_t PC_INIT     = 32'h8000_0000
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  // Redirect sources
  input  logic                 i_trap_valid,
  input  frontend_pkg::vaddr_t i_trap_vaddr,
  input  logic                 i_br_valid,
  input  frontend_pkg::vaddr_t i_br_vaddr,

  // Instruction cache
  input  logic                 i_ic_ready,
  input  logic                 i_ic_miss,
  input  frontend_pkg::vaddr_t i_ic_miss_vaddr,

  output logic                 o_fetch_valid,
  output frontend_pkg::vaddr_t o_fetch_vaddr
);

  import frontend_pkg::*;

  localparam vaddr_t BLK_MASK = vaddr_t'(FETCH_BYTES - 1);
  localparam vaddr_t BLK_STEP = vaddr_t'(FETCH_BYTES);

  fetch_state_t r_state;
  fetch_state_t w_state_next;
  vaddr_t       r_pc;            // Held fetch address
  vaddr_t       w_pc_next;

  logic         w_redirect;
  vaddr_t       w_redirect_vaddr;
  vaddr_t       w_req_vaddr;
  vaddr_t       w_req_blk_next;
  logic         w_req_accept;

  // ==================================================
  // Request address
  // ==================================================
  assign w_redirect       = i_trap_valid | i_br_valid;
  assign w_redirect_vaddr = i_trap_valid ? i_trap_vaddr : i_br_vaddr;  // Trap first

  // Redirect bypasses the held address in the same cycle
  assign w_req_vaddr    = w_redirect ? w_redirect_vaddr : r_pc;
  assign w_req_blk_next = (w_req_vaddr & ~BLK_MASK) + BLK_STEP;

  assign o_fetch_valid = (r_state == FETCH_REQ);
  assign o_fetch_vaddr = w_req_vaddr;
  assign w_req_accept  = o_fetch_valid & i_ic_ready;

  // ==================================================
  // State machine
  // ==================================================
  always_comb begin
    w_state_next = r_state;
    w_pc_next    = w_req_vaddr;  // Hold, or capture a redirect

    case (r_state)
      INIT : begin
        w_state_next = FETCH_REQ;
      end
      FETCH_REQ : begin
        if (i_ic_miss) begin
          // Retry the missed block once refilled
          w_state_next = WAIT_IC_FILL;
          w_pc_next    = w_redirect ? w_redirect_vaddr : i_ic_miss_vaddr;
        end else if (w_req_accept) begin
          w_pc_next = w_req_blk_next;
        end
      end
      WAIT_IC_FILL : begin
        if (i_ic_ready) begin
          w_state_next = FETCH_REQ;  // Held address goes out unchanged
        end
      end
      default : begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
      r_pc    <= PC_INIT;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  // No request while a refill is outstanding
  a_no_fetch_after_miss : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_ic_miss |=> !o_fetch_valid
  );

  // Cache reports a miss only for issued requests
  a_no_miss_in_fill : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (r_state == WAIT_IC_FILL) |-> !i_ic_miss
  );

endmodule

// ==== fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend #(
  parameter int unsigned          FETCH_BYTES = 16,
  parameter frontend_pkg::vaddr_t PC_INIT     = 32'h8000_0000
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // Interrupts
  input  logic                        i_int_valid,
  input  frontend_pkg::int_vec_t      i_int_pending,

  // Commit
  input  logic                        i_commit_valid,
  input  logic                        i_commit_flush,
  input  frontend_pkg::commit_cause_t i_commit_cause,
  input  frontend_pkg::vaddr_t        i_commit_epc,
  input  frontend_pkg::cmt_id_t       i_commit_cmt_id,

  // CSR values
  input  frontend_pkg::xlen_t         i_mtvec,
  input  frontend_pkg::xlen_t         i_stvec,
  input  frontend_pkg::xlen_t         i_mepc,
  input  frontend_pkg::xlen_t         i_sepc,
  input  frontend_pkg::xlen_t         i_medeleg,

  // Branch resolution
  input  logic                        i_br_mispredict,
  input  frontend_pkg::cmt_id_t       i_br_cmt_id,
  input  frontend_pkg::vaddr_t        i_br_target,

  // Instruction cache
  input  logic                        i_ic_ready,
  input  logic                        i_ic_miss,
  input  frontend_pkg::vaddr_t        i_ic_miss_vaddr,

  output logic                        o_fetch_valid,
  output frontend_pkg::vaddr_t        o_fetch_vaddr
);

  import frontend_pkg::*;

  logic   w_trap_valid;
  vaddr_t w_trap_vaddr;
  logic   w_br_valid;
  vaddr_t w_br_vaddr;

  trap_target_unit u_trap_target_unit (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_int_valid    (i_int_valid),
    .i_int_pending  (i_int_pending),
    .i_commit_valid (i_commit_valid),
    .i_commit_flush (i_commit_flush),
    .i_commit_cause (i_commit_cause),
    .i_commit_epc   (i_commit_epc),
    .i_mtvec        (i_mtvec),
    .i_stvec        (i_stvec),
    .i_mepc         (i_mepc),
    .i_sepc         (i_sepc),
    .i_medeleg      (i_medeleg),
    .o_trap_valid   (w_trap_valid),
    .o_trap_vaddr   (w_trap_vaddr)
  );

  branch_redirect_filter u_branch_redirect_filter (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_br_mispredict (i_br_mispredict),
    .i_br_cmt_id     (i_br_cmt_id),
    .i_br_target     (i_br_target),
    .i_commit_valid  (i_commit_valid),
    .i_commit_flush  (i_commit_flush),
    .i_commit_cmt_id (i_commit_cmt_id),
    .o_br_valid      (w_br_valid),
    .o_br_vaddr      (w_br_vaddr)
  );

  fetch_pc_sequencer #(
    .FETCH_BYTES (FETCH_BYTES),
    .PC_INIT     (PC_INIT)
  ) u_fetch_pc_sequencer (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trap_valid    (w_trap_valid),
    .i_trap_vaddr    (w_trap_vaddr),
    .i_br_valid      (w_br_valid),
    .i_br_vaddr      (w_br_vaddr),
    .i_ic_ready      (i_ic_ready),
    .i_ic_miss       (i_ic_miss),
    .i_ic_miss_vaddr (i_ic_miss_vaddr),
    .o_fetch_valid   (o_fetch_valid),
    .o_fetch_vaddr   (o_fetch_vaddr)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  // Released on a rising edge, so the first active edge is the next one
  initial begin
    o_reset_n = 1'b0;
    repeat (3) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

// ==== tb_fetch_frontend.sv ====
`timescale 1ns/1ps

module tb_fetch_frontend;

  import frontend_pkg::*;

  localparam int unsigned FETCH_BYTES = 16;
  localparam vaddr_t      PC_INIT     = 32'h8000_0000;
  localparam int          MAX_CYCLES  = 2000;  // Roughly twice the stimulus length

  logic          i_clk, i_reset_n, i_int_valid, i_commit_valid, i_commit_flush;
  logic          i_br_mispredict, i_ic_ready, i_ic_miss, o_fetch_valid;
  int_vec_t      i_int_pending;
  commit_cause_t i_commit_cause;
  cmt_id_t       i_commit_cmt_id, i_br_cmt_id;
  vaddr_t        i_commit_epc, i_br_target, i_ic_miss_vaddr, o_fetch_vaddr;
  xlen_t         i_mtvec, i_stvec, i_mepc, i_sepc, i_medeleg;

  fetch_state_t  m_state;      // Reference sequencer state
  vaddr_t        m_pc;
  logic          m_rec_valid;  // Reference branch record
  cmt_id_t       m_rec_id;
  logic [31:0]   rng_state = 32'd33;
  logic [31:0]   rnd;
  vaddr_t        exp_vaddr;
  int            cycle_count = 0;

  tb_clock_gen u_clock_gen (.o_clk(i_clk), .o_reset_n(i_reset_n));

  fetch_frontend #(.FETCH_BYTES(FETCH_BYTES), .PC_INIT(PC_INIT)) i_dut (.*);

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic commit_cause_t cause_from_index(input int i);
    case (i % 9)
      0       : return SILENT_FLUSH;
      1       : return REFETCH_FLUSH;
      2       : return MRET;
      3       : return SRET;
      4       : return ECALL_U;
      5       : return ECALL_S;
      6       : return ECALL_M;
      7       : return INST_ACC_FAULT;
      default : return ILLEGAL_INST;
    endcase
  endfunction

  // Codes 11, 9, 7, 5, 3, 1 from bit 5 down
  function automatic logic [3:0] int_cause_of(input int_vec_t p);
    for (int i = 5; i >= 0; i--) begin
      if (p[i]) return 2 * i + 1;
    end
    return 4'd0;
  endfunction

  // True when a committed before b
  function automatic logic id_older(input cmt_id_t a, input cmt_id_t b);
    return (a[4] == b[4]) ? (a[3:0] < b[3:0]) : (a[3:0] > b[3:0]);
  endfunction

  function automatic logic trap_expected();
    return i_int_valid || (i_commit_valid && i_commit_flush);
  endfunction

  function automatic logic branch_expected();
    return i_br_mispredict && !(i_commit_valid && i_commit_flush) &&
           !(m_rec_valid && id_older(m_rec_id, i_br_cmt_id));
  endfunction

  function automatic vaddr_t trap_target_expected();
    if (i_int_valid) return {i_mtvec[31:2], 2'b00} + 4 * int_cause_of(i_int_pending);
    case (i_commit_cause)
      SILENT_FLUSH  : return i_commit_epc + 4;
      REFETCH_FLUSH : return i_commit_epc;
      MRET          : return i_mepc;
      SRET          : return i_sepc;
      default       : return i_medeleg[i_commit_cause] ? i_stvec : i_mtvec;  // Exceptions
    endcase
  endfunction

  // Address the DUT has to present in the current cycle
  function automatic vaddr_t next_expected_vaddr();
    if (trap_expected()) return trap_target_expected();
    if (branch_expected()) return i_br_target;
    return m_pc;
  endfunction

  task automatic advance_model(input vaddr_t req);
    logic br_taken;
    logic redirect;
    br_taken = branch_expected();
    redirect = trap_expected() || br_taken;
    if (m_state == INIT) begin
      m_state = FETCH_REQ;
      m_pc    = req;
    end else if (m_state == WAIT_IC_FILL) begin
      m_pc = req;  // Refetched unchanged
      if (i_ic_ready) m_state = FETCH_REQ;
    end else if (i_ic_miss) begin
      m_state = WAIT_IC_FILL;
      m_pc    = redirect ? req : i_ic_miss_vaddr;
    end else begin
      m_pc = i_ic_ready ? (req & ~vaddr_t'(FETCH_BYTES - 1)) + FETCH_BYTES : req;
    end
    if (br_taken) begin
      m_rec_valid = 1'b1;
      m_rec_id    = i_br_cmt_id;
    end else if (i_commit_valid && (i_commit_flush || i_commit_cmt_id == m_rec_id)) begin
      m_rec_valid = 1'b0;
    end
  endtask

  // ==================================================
  // Checks
  // ==================================================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h (cycle %0d)",
             name, got, exp, cycle_count);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      m_state     = INIT;
      m_pc        = PC_INIT;
      m_rec_valid = 1'b0;
      m_rec_id    = '0;
    end else begin
      exp_vaddr = next_expected_vaddr();
      assert (o_fetch_valid === (m_state == FETCH_REQ)) else begin
        report_mismatch("o_fetch_valid", o_fetch_valid, m_state == FETCH_REQ);
      end
      assert (o_fetch_vaddr === exp_vaddr) else begin
        report_mismatch("o_fetch_vaddr", o_fetch_vaddr, exp_vaddr);
      end
      advance_model(exp_vaddr);
    end
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, stimulus did not finish", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic next_cycle();  // All strobes low unless overridden
    @(posedge i_clk);
    i_int_valid     <= 1'b0;
    i_commit_valid  <= 1'b0;
    i_commit_flush  <= 1'b0;
    i_br_mispredict <= 1'b0;
    i_ic_miss       <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic drive_commit(input commit_cause_t cause, input logic flush, input cmt_id_t id);
    i_commit_valid  <= 1'b1;
    i_commit_flush  <= flush;
    i_commit_cause  <= cause;
    i_commit_epc    <= next_random();
    i_commit_cmt_id <= id;
  endtask

  task automatic drive_mispredict(input cmt_id_t id, input vaddr_t target);
    i_br_mispredict <= 1'b1;
    i_br_cmt_id     <= id;
    i_br_target     <= target;
  endtask

  initial begin
    {i_int_valid, i_commit_valid, i_commit_flush, i_br_mispredict, i_ic_miss} = '0;
    {i_int_pending, i_commit_cmt_id, i_br_cmt_id} = '0;
    {i_commit_epc, i_br_target, i_ic_miss_vaddr} = '0;
    {i_mtvec, i_stvec, i_mepc, i_sepc, i_medeleg} = '0;
    i_commit_cause = SILENT_FLUSH;
    i_ic_ready     = 1'b1;
    @(posedge i_reset_n);

    idle(12);  // Sequential blocks from PC_INIT
    next_cycle();
    drive_mispredict(5'd0, 32'h8000_1236);  // Unaligned target
    idle(6);
    next_cycle();
    drive_commit(SILENT_FLUSH, 1'b0, 5'd0);  // Branch retires

    // Ready stalls, misses and refills
    repeat (250) begin
      next_cycle();
      rnd = next_random();
      i_ic_ready <= rnd[1:0] != 2'b00;
      if (m_state == FETCH_REQ && rnd[4:2] == 3'd0) begin
        i_ic_miss       <= 1'b1;
        i_ic_miss_vaddr <= next_random();
      end
    end

    // Interrupts racing commits and mispredicts
    repeat (150) begin
      next_cycle();
      rnd = next_random();
      i_ic_ready <= 1'b1;
      i_mtvec    <= next_random();
      if (rnd[0]) begin
        i_int_valid   <= 1'b1;
        i_int_pending <= (rnd[6:1] == 6'd0) ? 6'h01 : rnd[6:1];
      end
      if (rnd[8:7] == 2'b11) drive_commit(cause_from_index(rnd[12:9]), rnd[13], rnd[18:14]);
      if (rnd[20:19] == 2'b11) drive_mispredict(rnd[25:21], next_random());
    end

    // Every commit cause, delegation off, on and mixed
    for (int round = 0; round < 4; round++) begin
      for (int c = 0; c < 9; c++) begin
        next_cycle();
        i_mtvec   <= next_random();
        i_stvec   <= next_random();
        i_mepc    <= next_random();
        i_sepc    <= next_random();
        i_medeleg <= (round == 0) ? '0 : (round == 1) ? '1 : next_random();
        drive_commit(cause_from_index(c), 1'b1, 5'd0);
        idle(2);
      end
    end

    // Mispredict age filter
    next_cycle();
    drive_commit(REFETCH_FLUSH, 1'b1, 5'd0);
    next_cycle();
    drive_mispredict(5'b0_0011, 32'h8000_4000);
    next_cycle();
    drive_mispredict(5'b0_0101, 32'h8000_5000);  // Younger, dropped
    next_cycle();
    drive_mispredict(5'b1_0001, 32'h8000_6000);  // Younger across the wrap
    next_cycle();
    drive_commit(SILENT_FLUSH, 1'b0, 5'b0_0010);  // Record kept
    next_cycle();
    drive_commit(SILENT_FLUSH, 1'b0, 5'b0_0011);
    next_cycle();
    drive_mispredict(5'b0_0101, 32'h8000_7000);
    next_cycle();
    drive_mispredict(5'b0_0001, 32'h8000_8000);  // Older one still redirects
    repeat (200) begin
      next_cycle();
      rnd = next_random();
      if (rnd[1:0] == 2'b11) drive_mispredict(rnd[6:2] & 5'b10011, next_random());
      if (rnd[9:8] == 2'b11) begin
        drive_commit(cause_from_index(rnd[13:10]), rnd[15:14] == 2'b00, rnd[20:16] & 5'b10011);
      end
    end

    // Redirects around a cache-fill wait
    for (int k = 0; k < 3; k++) begin
      do next_cycle(); while (m_state != FETCH_REQ);
      i_ic_ready      <= 1'b0;
      i_ic_miss       <= 1'b1;
      i_ic_miss_vaddr <= 32'h8000_9004 + k * 32'h100;
      if (k == 2) drive_commit(REFETCH_FLUSH, 1'b1, 5'd0);  // Same cycle as the miss
      idle(3);
      next_cycle();
      if (k == 0) drive_commit(REFETCH_FLUSH, 1'b1, 5'd0);
      if (k == 1) drive_mispredict(5'd7, 32'h8000_a00c);
      idle(2);
      next_cycle();
      i_ic_ready <= 1'b1;
      idle(5);
    end

    idle(4);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
frontend_pkg.sv
trap_target_unit.sv
branch_redirect_filter.sv
fetch_pc_sequencer.sv
fetch_frontend.sv
tb_clock_gen.sv
tb_fetch_frontend.sv
